//--- all.f
+incdir+design
design/axil_mon_pkg.sv
design/axil_txn_counter.sv
design/axil_stall_timer.sv
design/axil_hold_checker.sv
design/axil_mon_csr.sv
design/axil_mon_top.sv
dv/tb_axil_mon.sv

//--- Makefile
# Verilator lint and simulation of the AXI-lite monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_axil_mon
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)

//--- dv/axil_mon_stimulus.txt
// Kind digit first. 0 bus: aw w b ar r rdata-flip count(2), channel digit valid/ready/flip|resp
// 1 write, 2 read: addr digit, data(4). 3 check: status(4) rd wr aw counts. 4 test label
400000001
20004000C
0CC000003
0000C0002
300000233
000C00003
00000C002
300000000
400000002
080000002
000000001
300001000
10000FFFF
080000001
090000001
0C0000001
00C000001
300001011
000C00001
10000FFFF
0000C0001
000008001
000000001
300010100
00000C001
10000FFFF
0000C0001
000008001
000008101
00000C001
300010000
10000FFFF
0CC000001
000D00001
300020000
10000FFFF
400000003
100020003
000080005
0000C0001
00000C001
300100000
10000FFFF
100020000
000080005
0000C0001
00000C001
300000000
100030003
0CC000001
000800005
000C00001
300200000
10000FFFF
100030000
0CC000001
000800005
000C00001
300000000
100040003
0CC000001
000000005
000C00001
300400000
10000FFFF
100040000
0CC000001
000000005
000C00001
300000000
400000004
00000C001
300040000
10000FFFF
0CC00000F
3000800FF
000C0000F
300080000
10000FFFF
400000005
10001FFBF
20001FFBF
00000D001
300020000
10001FFFF
00000D001
300060000
100000020
300040000
200000040
100000040
300000000
0CC000002
0000C0003
200050322
000C00002
00000C003
300000000

//--- dv/tb_axil_mon.sv
//////////////////////////////////////////////////
// Testbench for the AXI-lite monitor, run from a
// stimulus file of bus, register and check steps
//////////////////////////////////////////////////
`include "axil_mon_cfg.svh"

module tb_axil_mon;
	timeunit 1ns;
	timeprecision 100ps;

	// Step kinds, top digit of a record
	localparam logic [3:0] KIND_BUS   = 4'h0;
	localparam logic [3:0] KIND_WRITE = 4'h1;
	localparam logic [3:0] KIND_READ  = 4'h2;
	localparam logic [3:0] KIND_CHECK = 4'h3;
	localparam logic [3:0] KIND_LABEL = 4'h4;
	localparam logic [3:0] KIND_END   = 4'hF;
	localparam int NREC = 256;

	logic				clk = 1'b0;
	logic				axi_reset_n;
	logic				awvalid, awready, wvalid, wready;
	logic				bvalid, bready, arvalid, arready;
	logic				rvalid, rready;
	logic [`AXIL_MON_AW-1:0]	awaddr, araddr;
	logic [`AXIL_MON_DW-1:0]	wdata, rdata;
	logic [`AXIL_MON_DW/8-1:0]	wstrb;
	logic [1:0]			bresp, rresp;
	logic				cfg_wr, cfg_rd, cfg_rvalid, irq;
	axil_mon_pkg::csr_addr_e	cfg_addr;
	axil_mon_pkg::cfg_data_t	cfg_wdata, cfg_rdata;
	axil_mon_pkg::viol_vec_t	status;
	axil_mon_pkg::cnt_t		rd_out, wr_out, awr_out;

	logic [35:0]	steps [NREC];
	logic [31:0]	lfsr_state = 32'd12;
	int		test_id = 0;
	int		cycles = 0;
	int		cycle_limit = 100000;

	axil_mon_top dut0 (
		.i_clk(clk), .i_axi_reset_n(axi_reset_n),
		.i_axi_awvalid(awvalid), .i_axi_awready(awready), .i_axi_awaddr(awaddr),
		.i_axi_wvalid(wvalid), .i_axi_wready(wready), .i_axi_wdata(wdata),
		.i_axi_wstrb(wstrb), .i_axi_bvalid(bvalid), .i_axi_bready(bready),
		.i_axi_bresp(bresp), .i_axi_arvalid(arvalid), .i_axi_arready(arready),
		.i_axi_araddr(araddr), .i_axi_rvalid(rvalid), .i_axi_rready(rready),
		.i_axi_rdata(rdata), .i_axi_rresp(rresp),
		.i_cfg_wr(cfg_wr), .i_cfg_rd(cfg_rd), .i_cfg_addr(cfg_addr),
		.i_cfg_wdata(cfg_wdata), .o_cfg_rdata(cfg_rdata), .o_cfg_rvalid(cfg_rvalid),
		.o_irq(irq), .o_status(status), .o_rd_outstanding(rd_out),
		.o_wr_outstanding(wr_out), .o_awr_outstanding(awr_out)
	);

	always #4 clk = ~clk;

	// Watchdog sized from the stimulus length
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout: the run went past its limit of %0d cycles", cycle_limit);
			$display("Checks failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	function automatic string test_name(int id);
		case (id)
		0: return "reset";
		1: return "counting";
		2: return "stability";
		3: return "timeouts";
		4: return "protocol counting";
		5: return "register block";
		default: return "unknown";
		endcase
	endfunction

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Bus cycles a record occupies
	function automatic int step_cycles(logic [35:0] rec);
		case (rec[35:32])
		KIND_BUS: return (rec[7:0] == 8'd0) ? 1 : int'(rec[7:0]);
		KIND_WRITE, KIND_CHECK: return 1;
		KIND_READ: return 2;
		default: return 0;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("error in %s, %s: expected %0h, actual %0h",
				test_name(test_id), what, expected, actual);
			$display("Checks failed");
			$fatal(1, "run stopped at the first mismatch");
		end
	endtask

	// Drive one bus cycle; called right at a rising edge
	task automatic drive_bus(input logic [35:0] rec);
		logic [31:0] rnd;
		cfg_wr <= 1'b0;
		cfg_rd <= 1'b0;
		// A waiting channel keeps its payload unless the step flips it
		if (awvalid && !awready)
		begin
			if (rec[28])
				awaddr <= ~awaddr;
		end
		else
		begin
			draw_bits(`AXIL_MON_AW, rnd);
			awaddr <= rnd[`AXIL_MON_AW-1:0];
		end
		if (wvalid && !wready)
		begin
			if (rec[24])
				wdata <= ~wdata;
		end
		else
		begin
			draw_bits(`AXIL_MON_DW, rnd);
			wdata <= rnd[`AXIL_MON_DW-1:0];
			draw_bits(`AXIL_MON_DW/8, rnd);
			wstrb <= rnd[`AXIL_MON_DW/8-1:0];
		end
		if (arvalid && !arready)
		begin
			if (rec[16])
				araddr <= ~araddr;
		end
		else
		begin
			draw_bits(`AXIL_MON_AW, rnd);
			araddr <= rnd[`AXIL_MON_AW-1:0];
		end
		if (rvalid && !rready)
		begin
			if (rec[8])
				rdata <= ~rdata;
		end
		else
		begin
			draw_bits(`AXIL_MON_DW, rnd);
			rdata <= rnd[`AXIL_MON_DW-1:0];
		end
		awvalid <= rec[31];
		awready <= rec[30];
		wvalid  <= rec[27];
		wready  <= rec[26];
		bvalid  <= rec[23];
		bready  <= rec[22];
		bresp   <= rec[21:20];
		arvalid <= rec[19];
		arready <= rec[18];
		rvalid  <= rec[15];
		rready  <= rec[14];
		rresp   <= rec[13:12];
	endtask

	// Read strobe, then data one cycle later
	task automatic read_reg(input axil_mon_pkg::csr_addr_e addr, input logic [15:0] expected);
		@(posedge clk);
		drive_bus('0);
		cfg_rd   <= 1'b1;
		cfg_addr <= addr;
		@(posedge clk);
		drive_bus('0);
		@(negedge clk);
		check_value("read valid", 32'd1, 32'(cfg_rvalid));
		check_value($sformatf("read of register %0d", int'(addr)), 32'(expected),
			32'(cfg_rdata));
	endtask

	task automatic run_step(input logic [35:0] rec);
		int reps;
		case (rec[35:32])
		KIND_BUS:
		begin
			reps = step_cycles(rec);
			repeat (reps)
			begin
				@(posedge clk);
				drive_bus(rec);
			end
		end
		KIND_WRITE:
		begin
			@(posedge clk);
			drive_bus('0);
			cfg_wr    <= 1'b1;
			cfg_addr  <= axil_mon_pkg::csr_addr_e'(rec[18:16]);
			cfg_wdata <= rec[15:0];
		end
		KIND_READ:
			read_reg(axil_mon_pkg::csr_addr_e'(rec[18:16]), rec[15:0]);
		KIND_CHECK:
		begin
			// Idle cycle, then sample what the previous steps left behind
			@(posedge clk);
			drive_bus('0);
			@(negedge clk);
			check_value("status", 32'(rec[27:12]), 32'(status));
			check_value("irq", 32'(rec[27:12] != 16'h0), 32'(irq));
			check_value("read count", 32'(rec[11:8]), 32'(rd_out));
			check_value("write count", 32'(rec[7:4]), 32'(wr_out));
			check_value("address count", 32'(rec[3:0]), 32'(awr_out));
		end
		KIND_LABEL:
			test_id = int'(rec[7:0]);
		default:
		begin
			$display("a stimulus record has an unknown step kind %h", rec[35:32]);
			$display("Checks failed");
			$fatal(1, "run stopped on a bad stimulus record");
		end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	initial
	begin
		int idx;
		int total;
		axi_reset_n <= 1'b0;
		drive_bus('0);
		cfg_addr  <= axil_mon_pkg::CSR_STATUS;
		cfg_wdata <= '0;
		for (idx = 0; idx < NREC; idx++)
			steps[idx] = {KIND_END, 32'h0};
		$readmemh("dv/axil_mon_stimulus.txt", steps);
		total = 0;
		idx = 0;
		while ((idx < NREC) && (steps[idx][35:32] != KIND_END))
		begin
			total += step_cycles(steps[idx]);
			idx++;
		end
		cycle_limit = 16 + 4 * total + 100;

		repeat (16) @(posedge clk);
		axi_reset_n <= 1'b1;
		@(negedge clk);
		// Reset state, limits from the config header
		check_value("irq after reset", 32'd0, 32'(irq));
		check_value("read valid after reset", 32'd0, 32'(cfg_rvalid));
		check_value("status after reset", 32'd0, 32'(status));
		read_reg(axil_mon_pkg::CSR_MAXWAIT, 16'(`AXIL_MON_MAXWAIT_RST));
		read_reg(axil_mon_pkg::CSR_MAXRSTALL, 16'(`AXIL_MON_MAXRSTALL_RST));
		read_reg(axil_mon_pkg::CSR_ENABLE, 16'hFFFF);

		idx = 0;
		while ((idx < NREC) && (steps[idx][35:32] != KIND_END))
		begin
			run_step(steps[idx]);
			idx++;
		end
		$display("All checks passed");
		$finish;
	end

endmodule

//--- design/axil_mon_top.sv
//////////////////////////////////////////////////
// AXI-lite protocol monitor top level
//////////////////////////////////////////////////
`include "axil_mon_cfg.svh"

module axil_mon_top (
	input  logic				i_clk,
	input  logic				i_axi_reset_n,
	// Write address channel
	input  logic				i_axi_awvalid,
	input  logic				i_axi_awready,
	input  logic [`AXIL_MON_AW-1:0]		i_axi_awaddr,
	// Write data channel
	input  logic				i_axi_wvalid,
	input  logic				i_axi_wready,
	input  logic [`AXIL_MON_DW-1:0]		i_axi_wdata,
	input  logic [`AXIL_MON_DW/8-1:0]	i_axi_wstrb,
	// Write response channel
	input  logic				i_axi_bvalid,
	input  logic				i_axi_bready,
	input  logic [1:0]			i_axi_bresp,
	// Read address channel
	input  logic				i_axi_arvalid,
	input  logic				i_axi_arready,
	input  logic [`AXIL_MON_AW-1:0]		i_axi_araddr,
	// Read data channel
	input  logic				i_axi_rvalid,
	input  logic				i_axi_rready,
	input  logic [`AXIL_MON_DW-1:0]		i_axi_rdata,
	input  logic [1:0]			i_axi_rresp,
	// Configuration port
	input  logic				i_cfg_wr,
	input  logic				i_cfg_rd,
	input  axil_mon_pkg::csr_addr_e		i_cfg_addr,
	input  axil_mon_pkg::cfg_data_t		i_cfg_wdata,
	output axil_mon_pkg::cfg_data_t		o_cfg_rdata,
	output logic				o_cfg_rvalid,
	output logic				o_irq,
	output axil_mon_pkg::viol_vec_t		o_status,
	output axil_mon_pkg::cnt_t		o_rd_outstanding,
	output axil_mon_pkg::cnt_t		o_wr_outstanding,
	output axil_mon_pkg::cnt_t		o_awr_outstanding
);

	axil_mon_pkg::viol_vec_t	cnt_viol, tmr_viol, hold_viol;
	axil_mon_pkg::limit_t		max_wait, max_rstall, max_delay;

	axil_txn_counter u_cnt (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(i_axi_awvalid), .i_axi_awready(i_axi_awready),
		.i_axi_wvalid(i_axi_wvalid), .i_axi_wready(i_axi_wready),
		.i_axi_bvalid(i_axi_bvalid), .i_axi_bready(i_axi_bready),
		.i_axi_arvalid(i_axi_arvalid), .i_axi_arready(i_axi_arready),
		.i_axi_rvalid(i_axi_rvalid), .i_axi_rready(i_axi_rready),
		.o_rd_outstanding(o_rd_outstanding), .o_wr_outstanding(o_wr_outstanding),
		.o_awr_outstanding(o_awr_outstanding), .o_viol(cnt_viol)
	);

	// Timers see the live counts and limits
	axil_stall_timer u_tmr (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(i_axi_awvalid), .i_axi_awready(i_axi_awready),
		.i_axi_wvalid(i_axi_wvalid), .i_axi_wready(i_axi_wready),
		.i_axi_bvalid(i_axi_bvalid), .i_axi_bready(i_axi_bready),
		.i_axi_arvalid(i_axi_arvalid), .i_axi_arready(i_axi_arready),
		.i_axi_rvalid(i_axi_rvalid), .i_axi_rready(i_axi_rready),
		.i_rd_outstanding(o_rd_outstanding), .i_wr_outstanding(o_wr_outstanding),
		.i_awr_outstanding(o_awr_outstanding), .i_max_wait(max_wait),
		.i_max_rstall(max_rstall), .i_max_delay(max_delay), .o_viol(tmr_viol)
	);

	axil_hold_checker u_hold (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(i_axi_awvalid), .i_axi_awready(i_axi_awready),
		.i_axi_awaddr(i_axi_awaddr), .i_axi_wvalid(i_axi_wvalid),
		.i_axi_wready(i_axi_wready), .i_axi_wdata(i_axi_wdata),
		.i_axi_wstrb(i_axi_wstrb), .i_axi_bvalid(i_axi_bvalid),
		.i_axi_bready(i_axi_bready), .i_axi_bresp(i_axi_bresp),
		.i_axi_arvalid(i_axi_arvalid), .i_axi_arready(i_axi_arready),
		.i_axi_araddr(i_axi_araddr), .i_axi_rvalid(i_axi_rvalid),
		.i_axi_rready(i_axi_rready), .i_axi_rdata(i_axi_rdata),
		.i_axi_rresp(i_axi_rresp), .o_viol(hold_viol)
	);

	// Checkers own disjoint bits, so OR merges them
	axil_mon_csr u_csr (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_cfg_wr(i_cfg_wr), .i_cfg_rd(i_cfg_rd),
		.i_cfg_addr(i_cfg_addr), .i_cfg_wdata(i_cfg_wdata),
		.i_viol(cnt_viol | tmr_viol | hold_viol),
		.i_rd_outstanding(o_rd_outstanding), .i_wr_outstanding(o_wr_outstanding),
		.i_awr_outstanding(o_awr_outstanding),
		.o_cfg_rdata(o_cfg_rdata), .o_cfg_rvalid(o_cfg_rvalid),
		.o_status(o_status), .o_irq(o_irq), .o_max_wait(max_wait),
		.o_max_rstall(max_rstall), .o_max_delay(max_delay)
	);

endmodule

//--- design/axil_mon_csr.sv
//////////////////////////////////////////////////
// Limit registers, enable mask, sticky status and irq
//////////////////////////////////////////////////
module axil_mon_csr (
	input  logic				i_clk,
	input  logic				i_axi_reset_n,
	input  logic				i_cfg_wr,
	input  logic				i_cfg_rd,
	input  axil_mon_pkg::csr_addr_e		i_cfg_addr,
	input  axil_mon_pkg::cfg_data_t		i_cfg_wdata,
	input  axil_mon_pkg::viol_vec_t		i_viol,
	input  axil_mon_pkg::cnt_t		i_rd_outstanding,
	input  axil_mon_pkg::cnt_t		i_wr_outstanding,
	input  axil_mon_pkg::cnt_t		i_awr_outstanding,
	output axil_mon_pkg::cfg_data_t		o_cfg_rdata,
	output logic				o_cfg_rvalid,
	output axil_mon_pkg::viol_vec_t		o_status,
	output logic				o_irq,
	output axil_mon_pkg::limit_t		o_max_wait,
	output axil_mon_pkg::limit_t		o_max_rstall,
	output axil_mon_pkg::limit_t		o_max_delay
);

	axil_mon_pkg::viol_vec_t	enable;
	axil_mon_pkg::viol_vec_t	status;
	axil_mon_pkg::viol_vec_t	status_nxt;
	axil_mon_pkg::viol_vec_t	clr;

	// Write-one-to-clear, a new pulse beats a clear
	always_comb
	begin
		clr = '0;
		if (i_cfg_wr && (i_cfg_addr == axil_mon_pkg::CSR_STATUS))
			clr = i_cfg_wdata;
		status_nxt = (status & ~clr) | (i_viol & enable);
	end

	//////////////////////////////////////////////////
	// Control registers
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			enable       <= '1;
			status       <= '0;
			o_irq        <= 1'b0;
			o_max_wait   <= axil_mon_pkg::MAXWAIT_RST;
			o_max_rstall <= axil_mon_pkg::MAXRSTALL_RST;
			o_max_delay  <= axil_mon_pkg::MAXDELAY_RST;
		end
		else
		begin
			status <= status_nxt;
			// Irq follows the status on the same edge
			o_irq  <= |status_nxt;
			if (i_cfg_wr)
			begin
				case (i_cfg_addr)
				axil_mon_pkg::CSR_ENABLE:    enable       <= i_cfg_wdata;
				axil_mon_pkg::CSR_MAXWAIT:   o_max_wait   <= axil_mon_pkg::limit_t'(i_cfg_wdata);
				axil_mon_pkg::CSR_MAXRSTALL: o_max_rstall <= axil_mon_pkg::limit_t'(i_cfg_wdata);
				axil_mon_pkg::CSR_MAXDELAY:  o_max_delay  <= axil_mon_pkg::limit_t'(i_cfg_wdata);
				default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Read-back, one cycle after the strobe
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_cfg_rvalid <= 1'b0;
		else
			o_cfg_rvalid <= i_cfg_rd;
	end

	always_ff @(posedge i_clk)
	begin
		case (i_cfg_addr)
		axil_mon_pkg::CSR_STATUS:    o_cfg_rdata <= status;
		axil_mon_pkg::CSR_ENABLE:    o_cfg_rdata <= enable;
		axil_mon_pkg::CSR_MAXWAIT:   o_cfg_rdata <= axil_mon_pkg::cfg_data_t'(o_max_wait);
		axil_mon_pkg::CSR_MAXRSTALL: o_cfg_rdata <= axil_mon_pkg::cfg_data_t'(o_max_rstall);
		axil_mon_pkg::CSR_MAXDELAY:  o_cfg_rdata <= axil_mon_pkg::cfg_data_t'(o_max_delay);
		// Read count on top, then write, then address
		axil_mon_pkg::CSR_OUTSTANDING:
			o_cfg_rdata <= axil_mon_pkg::cfg_data_t'({i_rd_outstanding,
				i_wr_outstanding, i_awr_outstanding});
		default: o_cfg_rdata <= '0;
		endcase
	end

	assign o_status = status;

endmodule

//--- design/axil_hold_checker.sv
//////////////////////////////////////////////////
// Payload stability and EXOKAY response checks
//////////////////////////////////////////////////
module axil_hold_checker (
	input  logic			i_clk,
	input  logic			i_axi_reset_n,
	input  logic			i_axi_awvalid,
	input  logic			i_axi_awready,
	input  axil_mon_pkg::addr_t	i_axi_awaddr,
	input  logic			i_axi_wvalid,
	input  logic			i_axi_wready,
	input  axil_mon_pkg::data_t	i_axi_wdata,
	input  axil_mon_pkg::strb_t	i_axi_wstrb,
	input  logic			i_axi_bvalid,
	input  logic			i_axi_bready,
	input  logic [1:0]		i_axi_bresp,
	input  logic			i_axi_arvalid,
	input  logic			i_axi_arready,
	input  axil_mon_pkg::addr_t	i_axi_araddr,
	input  logic			i_axi_rvalid,
	input  logic			i_axi_rready,
	input  axil_mon_pkg::data_t	i_axi_rdata,
	input  logic [1:0]		i_axi_rresp,
	output axil_mon_pkg::viol_vec_t	o_viol
);

	localparam logic [1:0] RESP_EXOKAY = 2'b01;

	// Valid without ready on the previous cycle
	logic			aw_wait, w_wait, ar_wait, b_wait, r_wait;
	axil_mon_pkg::addr_t	awaddr_q, araddr_q;
	axil_mon_pkg::data_t	wdata_q, rdata_q;
	axil_mon_pkg::strb_t	wstrb_q;
	logic [1:0]		bresp_q, rresp_q;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_wait <= 1'b0;
			w_wait  <= 1'b0;
			ar_wait <= 1'b0;
			b_wait  <= 1'b0;
			r_wait  <= 1'b0;
		end
		else
		begin
			aw_wait <= i_axi_awvalid && !i_axi_awready;
			w_wait  <= i_axi_wvalid && !i_axi_wready;
			ar_wait <= i_axi_arvalid && !i_axi_arready;
			b_wait  <= i_axi_bvalid && !i_axi_bready;
			r_wait  <= i_axi_rvalid && !i_axi_rready;
		end
	end

	// Payload snapshot for comparison next cycle
	always_ff @(posedge i_clk)
	begin
		awaddr_q <= i_axi_awaddr;
		wdata_q  <= i_axi_wdata;
		wstrb_q  <= i_axi_wstrb;
		bresp_q  <= i_axi_bresp;
		araddr_q <= i_axi_araddr;
		rdata_q  <= i_axi_rdata;
		rresp_q  <= i_axi_rresp;
	end

	always_comb
	begin
		o_viol = '0;
		// Valid dropped or payload moved while waiting
		o_viol[axil_mon_pkg::VIOL_AW_HOLD] = aw_wait
			&& (!i_axi_awvalid || (i_axi_awaddr != awaddr_q));
		o_viol[axil_mon_pkg::VIOL_W_HOLD] = w_wait && (!i_axi_wvalid
			|| (i_axi_wdata != wdata_q) || (i_axi_wstrb != wstrb_q));
		o_viol[axil_mon_pkg::VIOL_AR_HOLD] = ar_wait
			&& (!i_axi_arvalid || (i_axi_araddr != araddr_q));
		o_viol[axil_mon_pkg::VIOL_B_HOLD] = b_wait
			&& (!i_axi_bvalid || (i_axi_bresp != bresp_q));
		o_viol[axil_mon_pkg::VIOL_R_HOLD] = r_wait && (!i_axi_rvalid
			|| (i_axi_rdata != rdata_q) || (i_axi_rresp != rresp_q));
		// Exclusive access is not part of AXI-lite
		o_viol[axil_mon_pkg::VIOL_EXOKAY] = (i_axi_bvalid && (i_axi_bresp == RESP_EXOKAY))
			|| (i_axi_rvalid && (i_axi_rresp == RESP_EXOKAY));
	end

endmodule

//--- design/axil_stall_timer.sv
//////////////////////////////////////////////////
// Request stall, response stall and ack delay timers
//////////////////////////////////////////////////
module axil_stall_timer (
	input  logic			i_clk,
	input  logic			i_axi_reset_n,
	input  logic			i_axi_awvalid,
	input  logic			i_axi_awready,
	input  logic			i_axi_wvalid,
	input  logic			i_axi_wready,
	input  logic			i_axi_bvalid,
	input  logic			i_axi_bready,
	input  logic			i_axi_arvalid,
	input  logic			i_axi_arready,
	input  logic			i_axi_rvalid,
	input  logic			i_axi_rready,
	input  axil_mon_pkg::cnt_t	i_rd_outstanding,
	input  axil_mon_pkg::cnt_t	i_wr_outstanding,
	input  axil_mon_pkg::cnt_t	i_awr_outstanding,
	input  axil_mon_pkg::limit_t	i_max_wait,
	input  axil_mon_pkg::limit_t	i_max_rstall,
	input  axil_mon_pkg::limit_t	i_max_delay,
	output axil_mon_pkg::viol_vec_t	o_viol
);

	// Timer slots: aw, w, ar, b, r, write delay, read delay
	localparam int NT = 7;

	logic [NT-1:0]		run;
	logic [NT-1:0]		hit;
	axil_mon_pkg::limit_t	timer [NT];
	axil_mon_pkg::limit_t	limit [NT];

	//////////////////////////////////////////////////
	// Qualifying conditions
	always_comb
	begin
		// Request stalls, excused while a response backs up
		run[0] = i_axi_awvalid && !i_axi_awready && !i_axi_bvalid;
		run[1] = i_axi_wvalid && !i_axi_wready && !i_axi_bvalid;
		run[2] = i_axi_arvalid && !i_axi_arready && !i_axi_rvalid;
		// Response stalls
		run[3] = i_axi_bvalid && !i_axi_bready;
		run[4] = i_axi_rvalid && !i_axi_rready;
		// Pending requests with no response in sight
		run[5] = (i_awr_outstanding != '0) && (i_wr_outstanding != '0)
			&& !i_axi_bvalid;
		run[6] = (i_rd_outstanding != '0) && !i_axi_rvalid;
		limit[0] = i_max_wait;
		limit[1] = i_max_wait;
		limit[2] = i_max_wait;
		limit[3] = i_max_rstall;
		limit[4] = i_max_rstall;
		limit[5] = i_max_delay;
		limit[6] = i_max_delay;
	end

	//////////////////////////////////////////////////
	// Timers, cleared as soon as the condition ends
	always_ff @(posedge i_clk)
	begin
		for (int k = 0; k < NT; k++)
		begin
			if (!i_axi_reset_n || !run[k])
				timer[k] <= '0;
			else if (!(&timer[k]))
				timer[k] <= timer[k] + 1'b1;
		end
	end

	// Zero limit turns the check off
	always_comb
	begin
		for (int k = 0; k < NT; k++)
			hit[k] = run[k] && (limit[k] != '0) && (timer[k] >= limit[k]);
	end

	always_comb
	begin
		o_viol = '0;
		o_viol[axil_mon_pkg::VIOL_REQ_STALL]  = |hit[2:0];
		o_viol[axil_mon_pkg::VIOL_RESP_STALL] = |hit[4:3];
		o_viol[axil_mon_pkg::VIOL_ACK_DELAY]  = |hit[6:5];
	end

endmodule

//--- design/axil_txn_counter.sv
//////////////////////////////////////////////////
// Outstanding request counters, overflow and
// unrequested response detection
//////////////////////////////////////////////////
module axil_txn_counter (
	input  logic			i_clk,
	input  logic			i_axi_reset_n,
	input  logic			i_axi_awvalid,
	input  logic			i_axi_awready,
	input  logic			i_axi_wvalid,
	input  logic			i_axi_wready,
	input  logic			i_axi_bvalid,
	input  logic			i_axi_bready,
	input  logic			i_axi_arvalid,
	input  logic			i_axi_arready,
	input  logic			i_axi_rvalid,
	input  logic			i_axi_rready,
	output axil_mon_pkg::cnt_t	o_rd_outstanding,
	output axil_mon_pkg::cnt_t	o_wr_outstanding,
	output axil_mon_pkg::cnt_t	o_awr_outstanding,
	output axil_mon_pkg::viol_vec_t	o_viol
);

	// Handshakes on each channel
	logic	aw_req, w_req, ar_req, b_ack, r_ack;

	// Saturating up, floor at zero going down
	function automatic axil_mon_pkg::cnt_t step(axil_mon_pkg::cnt_t cnt,
		logic inc, logic dec);
		axil_mon_pkg::cnt_t nxt;
		nxt = cnt;
		if (inc && !dec && !(&cnt))
			nxt = cnt + 1'b1;
		else if (dec && !inc && (cnt != '0))
			nxt = cnt - 1'b1;
		return nxt;
	endfunction

	// Request accepted at or past one below full
	function automatic logic near_full(axil_mon_pkg::cnt_t cnt, logic inc);
		return inc && (cnt >= {{($bits(cnt)-1){1'b1}}, 1'b0});
	endfunction

	assign aw_req = i_axi_awvalid && i_axi_awready;
	assign w_req  = i_axi_wvalid && i_axi_wready;
	assign ar_req = i_axi_arvalid && i_axi_arready;
	assign b_ack  = i_axi_bvalid && i_axi_bready;
	assign r_ack  = i_axi_rvalid && i_axi_rready;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_outstanding <= '0;
			o_wr_outstanding  <= '0;
			o_rd_outstanding  <= '0;
		end
		else
		begin
			// A write response retires both address and data
			o_awr_outstanding <= step(o_awr_outstanding, aw_req, b_ack);
			o_wr_outstanding  <= step(o_wr_outstanding, w_req, b_ack);
			o_rd_outstanding  <= step(o_rd_outstanding, ar_req, r_ack);
		end
	end

	always_comb
	begin
		o_viol = '0;
		o_viol[axil_mon_pkg::VIOL_OVERFLOW] = near_full(o_awr_outstanding, aw_req)
			|| near_full(o_wr_outstanding, w_req)
			|| near_full(o_rd_outstanding, ar_req);
		// Response valid with nothing pending
		o_viol[axil_mon_pkg::VIOL_UNREQ_RESP] = (i_axi_bvalid
			&& ((o_awr_outstanding == '0) || (o_wr_outstanding == '0)))
			|| (i_axi_rvalid && (o_rd_outstanding == '0));
	end

endmodule

//--- design/axil_mon_pkg.sv
//////////////////////////////////////////////////
// Violation and register enums, shared vector types
//////////////////////////////////////////////////
`include "axil_mon_cfg.svh"

package axil_mon_pkg;

	// Bit positions inside a violation vector
	typedef enum logic [3:0] {
		VIOL_AW_HOLD	= 4'd0,
		VIOL_W_HOLD	= 4'd1,
		VIOL_AR_HOLD	= 4'd2,
		VIOL_B_HOLD	= 4'd3,
		VIOL_R_HOLD	= 4'd4,
		VIOL_EXOKAY	= 4'd5,
		VIOL_UNREQ_RESP	= 4'd6,
		VIOL_OVERFLOW	= 4'd7,
		VIOL_REQ_STALL	= 4'd8,
		VIOL_RESP_STALL	= 4'd9,
		VIOL_ACK_DELAY	= 4'd10
	} viol_e;

	typedef logic [15:0] viol_vec_t;

	// Configuration register map
	typedef enum logic [`AXIL_MON_CSR_AW-1:0] {
		CSR_STATUS	= 0,
		CSR_ENABLE	= 1,
		CSR_MAXWAIT	= 2,
		CSR_MAXRSTALL	= 3,
		CSR_MAXDELAY	= 4,
		CSR_OUTSTANDING	= 5
	} csr_addr_e;

	typedef logic [15:0]			cfg_data_t;
	typedef logic [`AXIL_MON_LGDEPTH-1:0]	cnt_t;
	typedef logic [`AXIL_MON_LGTIMEOUT-1:0]	limit_t;
	typedef logic [`AXIL_MON_AW-1:0]	addr_t;
	typedef logic [`AXIL_MON_DW-1:0]	data_t;
	typedef logic [`AXIL_MON_DW/8-1:0]	strb_t;

	// Limit values after reset
	localparam limit_t MAXWAIT_RST		= `AXIL_MON_MAXWAIT_RST;
	localparam limit_t MAXRSTALL_RST	= `AXIL_MON_MAXRSTALL_RST;
	localparam limit_t MAXDELAY_RST		= `AXIL_MON_MAXDELAY_RST;

endpackage

//--- design/axil_mon_cfg.svh
//////////////////////////////////////////////////
// Bus widths, counter depth, limit width and the
// reset values of the monitor's run-time limits
//////////////////////////////////////////////////
`ifndef AXIL_MON_CFG_SVH
`define AXIL_MON_CFG_SVH

// AXI-lite bus widths
`define AXIL_MON_AW		28
`define AXIL_MON_DW		32

// Outstanding counter width and limit/timer width
`define AXIL_MON_LGDEPTH	4
`define AXIL_MON_LGTIMEOUT	8

// Limits loaded at reset, zero would disable a check
`define AXIL_MON_MAXWAIT_RST	12
`define AXIL_MON_MAXRSTALL_RST	12
`define AXIL_MON_MAXDELAY_RST	12

// Configuration port address width
`define AXIL_MON_CSR_AW		3

`endif
